//--- flist.f
rtl/ps2_pkg.sv
rtl/hex_seg_decode.sv
rtl/ps2_frame_rx.sv
rtl/scan_fifo.sv
rtl/key_out.sv
rtl/ps2_kbd_top.sv
tests/tb_checker.sv
tests/tb_ps2_kbd.sv

//--- rtl/hex_seg_decode.sv
`timescale 1ns/100ps

module hex_seg_decode (
    input  logic [3:0]     nibble,
    output ps2_pkg::seg7_t seg
);

    // segments abcdefg from bit 6 down, a low bit lights the segment.
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b0000001;
            4'h1: seg = 7'b1001111;
            4'h2: seg = 7'b0010010;
            4'h3: seg = 7'b0000110;
            4'h4: seg = 7'b1001100;
            4'h5: seg = 7'b0100100;
            4'h6: seg = 7'b0100000;
            4'h7: seg = 7'b0001111;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0000100;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b1100000; // lower case b.
            4'hc: seg = 7'b0110001;
            4'hd: seg = 7'b1000010; // lower case d.
            4'he: seg = 7'b0110000;
            4'hf: seg = 7'b0111000;
            default: seg = '1;
        endcase
    end

endmodule

//--- rtl/key_out.sv
`timescale 1ns/100ps

module key_out (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::scan_byte_t head,
    input  logic                empty,
    input  logic                ack,
    output logic                pop,
    output logic                req,
    output ps2_pkg::scan_byte_t key_data,
    output ps2_pkg::seg7_t      seg_lo,
    output ps2_pkg::seg7_t      seg_hi
);

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_RELEASE
    } out_state_t;

    out_state_t     state;
    ps2_pkg::seg7_t dig_lo;
    ps2_pkg::seg7_t dig_hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= OUT_IDLE;
        end else begin
            case (state)
                OUT_IDLE: begin
                    if (!empty && !ack) begin
                        state <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (ack) begin
                        state <= OUT_RELEASE;
                    end
                end
                OUT_RELEASE: begin
                    if (!ack) begin
                        state <= OUT_IDLE; // the consumer has finished this byte.
                    end
                end
                default: state <= OUT_IDLE;
            endcase
        end
    end

    // key_data is taken from the head on the edge where req rises.
    always_ff @(posedge clk) begin
        if (state == OUT_IDLE && !empty && !ack) begin
            key_data <= head;
        end
    end

    assign req = (state == OUT_REQ);
    assign pop = (state == OUT_REQ) && ack; // head leaves as req falls.

    hex_seg_decode u_dig_lo (
        .nibble (key_data[3:0]),
        .seg    (dig_lo)
    );

    hex_seg_decode u_dig_hi (
        .nibble (key_data[7:4]),
        .seg    (dig_hi)
    );

    assign seg_lo = req ? dig_lo : '1;
    assign seg_hi = req ? dig_hi : '1;

    a_data_stable: assert property (
        @(posedge clk) disable iff (rst) req |=> !req || $stable(key_data)
    );

endmodule

//--- rtl/ps2_frame_rx.sv
`timescale 1ns/100ps

module ps2_frame_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic              ps2_clk,
    input  logic              ps2_data,
    output ps2_pkg::rx_byte_s rx_byte,
    output logic              frame_error
);

    logic [1:0]          clk_sync;
    logic [1:0]          data_sync;
    logic                clk_last;
    logic                fall;
    logic                data_bit;
    ps2_pkg::rx_state_t  state;
    logic [2:0]          bit_cnt;
    ps2_pkg::scan_byte_t shift;
    logic                start_bad;
    logic                parity_ok;
    logic                strobe;

    // both lines idle high, so the flops come out of reset high.
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_last  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_last  <= clk_sync[1];
        end
    end

    assign fall     = clk_last & ~clk_sync[1];
    assign data_bit = data_sync[1]; // same depth as the clock path.

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ps2_pkg::RX_IDLE;
            bit_cnt     <= '0;
            start_bad   <= 1'b0;
            parity_ok   <= 1'b0;
            strobe      <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            strobe <= 1'b0;
            if (fall) begin
                case (state)
                    ps2_pkg::RX_IDLE: begin
                        start_bad <= data_bit; // a good start bit is low.
                        bit_cnt   <= '0;
                        state     <= ps2_pkg::RX_DATA;
                    end
                    ps2_pkg::RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ps2_pkg::RX_PARITY;
                        end
                    end
                    ps2_pkg::RX_PARITY: begin
                        parity_ok <= ^{shift, data_bit}; // odd parity over nine bits.
                        state     <= ps2_pkg::RX_STOP;
                    end
                    ps2_pkg::RX_STOP: begin
                        if (!start_bad && parity_ok && data_bit) begin
                            strobe <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state <= ps2_pkg::RX_IDLE;
                    end
                    default: state <= ps2_pkg::RX_IDLE;
                endcase
            end
        end
    end

    // data arrives lsb first, so it enters at the top and moves down.
    always_ff @(posedge clk) begin
        if (fall && state == ps2_pkg::RX_DATA) begin
            shift <= {data_bit, shift[7:1]};
        end
    end

    assign rx_byte = '{valid: strobe, data: shift};

    // A frame spans at least eleven PS/2 edges, so strobes never touch.
    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst) strobe |=> !strobe
    );

endmodule

//--- rtl/ps2_kbd_top.sv
`timescale 1ns/100ps

module ps2_kbd_top #(
    parameter int FIFO_ADDR_W = ps2_pkg::FIFO_ADDR_W_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                ack,
    output logic                req,
    output ps2_pkg::scan_byte_t key_data,
    output ps2_pkg::seg7_t      seg_lo,
    output ps2_pkg::seg7_t      seg_hi,
    output logic                frame_error,
    output logic                overflow
);

    ps2_pkg::rx_byte_s   rx_byte;
    ps2_pkg::scan_byte_t head;
    logic                empty;
    logic                pop;

    ps2_frame_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .frame_error (frame_error)
    );

    scan_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .rx_byte  (rx_byte),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .overflow (overflow)
    );

    key_out u_out (
        .clk      (clk),
        .rst      (rst),
        .head     (head),
        .empty    (empty),
        .ack      (ack),
        .pop      (pop),
        .req      (req),
        .key_data (key_data),
        .seg_lo   (seg_lo),
        .seg_hi   (seg_hi)
    );

endmodule

//--- rtl/ps2_pkg.sv
package ps2_pkg;

    // one scan-code byte as it arrives on the PS/2 data line.
    typedef logic [7:0] scan_byte_t;

    // active-low segment pattern, bit 6 is segment a and bit 0 is segment g.
    typedef logic [6:0] seg7_t;

    // position inside an 11-bit PS/2 frame.
    // the start bit is taken in the idle state.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // a received byte with its one-cycle strobe.
    typedef struct packed {
        logic       valid;
        scan_byte_t data;
    } rx_byte_s;

    // eight FIFO entries unless the top level says otherwise.
    parameter int FIFO_ADDR_W_DEFAULT = 3;

endpackage

//--- rtl/scan_fifo.sv
`timescale 1ns/100ps

module scan_fifo #(
    parameter int FIFO_ADDR_W = ps2_pkg::FIFO_ADDR_W_DEFAULT
) (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::rx_byte_s   rx_byte,
    input  logic                pop,
    output ps2_pkg::scan_byte_t head,
    output logic                empty,
    output logic                overflow
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    ps2_pkg::scan_byte_t  mem [DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 full;
    logic                 push;

    // the extra pointer bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                   (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    // a pop in the same cycle frees the slot the write lands in.
    assign push = rx_byte.valid && (!full || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= rx_byte.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rx_byte.valid && full && !pop) begin
                overflow <= 1'b1; // the new byte is lost, stored ones stay.
            end
        end
    end

    assign head = mem[rd_ptr[FIFO_ADDR_W-1:0]];

    // key_out only pops a byte it has already offered.
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    );

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  ps2_pkg::scan_byte_t key_data,
    input  ps2_pkg::seg7_t      seg_lo,
    input  ps2_pkg::seg7_t      seg_hi,
    input  logic                frame_error,
    input  logic                overflow,
    output logic                ack
);

    ps2_pkg::scan_byte_t exp_q [$];
    string               test_name = "none";
    int                  test_errors = 0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  ack_delay = 2;
    logic                hold_ack = 1'b0;
    logic                req_d;
    logic                ack_d;
    ps2_pkg::scan_byte_t held;
    ps2_pkg::scan_byte_t shown;

    // segments abcdefg run from bit 6 down and lit segments are zero.
    function automatic ps2_pkg::seg7_t seg_ref(input logic [3:0] n);
        case (n)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'ha: return 7'b0001000;
            4'hb: return 7'b1100000;
            4'hc: return 7'b0110001;
            4'hd: return 7'b1000010;
            4'he: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    task automatic fail_value(input string what, input logic [7:0] exp, input logic [7:0] act);
        $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
        test_errors++;
        errors++;
    endtask

    task automatic fail_note(input string msg);
        $display("error in %s: %s", test_name, msg);
        test_errors++;
        errors++;
    endtask

    task automatic expect_byte(input logic [7:0] b);
        exp_q.push_back(b);
    endtask

    task automatic set_consumer(input int delay, input logic hold);
        ack_delay = delay;
        hold_ack  = hold;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (exp_q.size() != 0) begin
            fail_note($sformatf("%0d expected bytes were never offered.", exp_q.size()));
            exp_q.delete();
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s done, no mismatches.", test_name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors.", test_name, test_errors);
        end
    endtask

    task automatic check_flags(input logic exp_fe, input logic exp_ov);
        if (frame_error !== exp_fe) fail_value("frame_error", exp_fe, frame_error);
        if (overflow !== exp_ov) fail_value("overflow", exp_ov, overflow);
    endtask

    task automatic report_totals();
        $display("%0d tests run, %0d failed, %0d errors in total.", tests_run,
                 tests_failed, errors);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    function automatic int total_errors();
        return errors;
    endfunction

    // the consumer answers each req with ack after a set delay.
    initial begin
        ack = 1'b0;
        forever begin
            @(posedge clk);
            if (req && !ack && !hold_ack) begin
                repeat (ack_delay) @(posedge clk);
                #2 ack = 1'b1;
                while (req) @(posedge clk);
                #2 ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            req_d <= 1'b0;
            ack_d <= 1'b0;
        end else begin
            if (req && !req_d) begin
                if (ack_d) fail_note("req rose while ack was still high.");
                if (exp_q.size() == 0) begin
                    fail_note("req rose with no byte expected.");
                    shown = key_data;
                end else begin
                    shown = exp_q.pop_front();
                    if (key_data !== shown) fail_value("key_data", shown, key_data);
                end
                held <= key_data;
            end
            if (req && req_d && key_data !== held) begin
                fail_note("key_data changed while req was high.");
            end
            if (!req && req_d && !ack_d) fail_note("req fell before ack was raised.");
            if (req) begin
                if (seg_lo !== seg_ref(shown[3:0])) begin
                    fail_value("seg_lo", seg_ref(shown[3:0]), seg_lo);
                end
                if (seg_hi !== seg_ref(shown[7:4])) begin
                    fail_value("seg_hi", seg_ref(shown[7:4]), seg_hi);
                end
            end else if (seg_lo !== 7'h7f || seg_hi !== 7'h7f) begin
                fail_note("segments were not blank while req was low.");
            end
            req_d <= req;
            ack_d <= ack;
        end
    end

endmodule

//--- tests/tb_ps2_kbd.sv
`timescale 1ns/100ps

module tb_ps2_kbd;

    localparam int FIFO_ADDR_W    = ps2_pkg::FIFO_ADDR_W_DEFAULT;
    localparam int FIFO_DEPTH     = 2 ** FIFO_ADDR_W;
    localparam int NUM_FRAMES     = 20 + 7 + 16 + 5 + FIFO_DEPTH + 1;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 11 * 12 + 2000;

    localparam int CORRUPT_NONE   = 0;
    localparam int CORRUPT_START  = 1;
    localparam int CORRUPT_PARITY = 2;
    localparam int CORRUPT_STOP   = 3;

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_data;
    logic                ack;
    logic                req;
    ps2_pkg::scan_byte_t key_data;
    ps2_pkg::seg7_t      seg_lo;
    ps2_pkg::seg7_t      seg_hi;
    logic                frame_error;
    logic                overflow;
    logic [31:0]         rng_state;
    int                  cycle_count = 0;
    int                  i;
    logic [3:0]          nib;

    ps2_kbd_top #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .ack         (ack),
        .req         (req),
        .key_data    (key_data),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    tb_checker u_chk (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .key_data    (key_data),
        .seg_lo      (seg_lo),
        .seg_hi      (seg_hi),
        .frame_error (frame_error),
        .overflow    (overflow),
        .ack         (ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // bit 0 goes out first, so the byte sits lsb first above the start bit.
    function automatic logic [10:0] build_frame(input logic [7:0] b, input int corrupt);
        logic [10:0] bits;
        bits = {1'b1, ~^b, b, 1'b0};
        case (corrupt)
            CORRUPT_START:  bits[0]  = 1'b1;
            CORRUPT_PARITY: bits[9]  = ~bits[9];
            CORRUPT_STOP:   bits[10] = 1'b0;
            default: ;
        endcase
        return bits;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // the flags are sticky and only a reset clears them.
    task automatic apply_reset();
        rst = 1'b1;
        step(8);
        rst = 1'b0;
        step(4);
    endtask

    // each PS/2 half period lasts six clk cycles and data changes while the line is high.
    task automatic send_frame(input logic [10:0] bits);
        for (int k = 0; k < 11; k++) begin
            ps2_data = bits[k];
            step(6);
            ps2_clk = 1'b0;
            step(6);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step(12);
    endtask

    task automatic send_good(input logic [7:0] b);
        u_chk.expect_byte(b);
        send_frame(build_frame(b, CORRUPT_NONE));
    endtask

    task automatic wait_idle();
        step(1);
        while (u_chk.pending_count() != 0 || req || ack) begin
            step(1);
        end
        step(6);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish.", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        rng_state = 32'hcb82f2ee;
        apply_reset();

        u_chk.begin_test("random_bytes");
        u_chk.set_consumer(2, 1'b0);
        for (i = 0; i < 20; i++) begin
            send_good(next_byte());
        end
        wait_idle();
        u_chk.end_test();

        u_chk.begin_test("bad_frames");
        u_chk.check_flags(1'b0, 1'b0);
        send_good(next_byte());
        wait_idle();
        send_frame(build_frame(next_byte(), CORRUPT_PARITY));
        wait_idle();
        u_chk.check_flags(1'b1, 1'b0);
        send_good(next_byte());
        wait_idle();
        apply_reset();
        u_chk.check_flags(1'b0, 1'b0);
        send_frame(build_frame(next_byte(), CORRUPT_START));
        wait_idle();
        u_chk.check_flags(1'b1, 1'b0);
        send_good(next_byte());
        wait_idle();
        apply_reset();
        u_chk.check_flags(1'b0, 1'b0);
        send_frame(build_frame(next_byte(), CORRUPT_STOP));
        wait_idle();
        u_chk.check_flags(1'b1, 1'b0);
        send_good(next_byte());
        wait_idle();
        u_chk.end_test();

        // every nibble value shows up once on each digit.
        u_chk.begin_test("hex_digits");
        for (i = 0; i < 16; i++) begin
            nib = i[3:0];
            send_good({~nib, nib});
        end
        wait_idle();
        u_chk.end_test();

        u_chk.begin_test("slow_consumer");
        u_chk.set_consumer(50, 1'b0);
        for (i = 0; i < 5; i++) begin
            send_good(next_byte());
        end
        wait_idle();
        u_chk.check_flags(1'b1, 1'b0);
        u_chk.end_test();

        u_chk.begin_test("overflow");
        u_chk.set_consumer(2, 1'b1);
        for (i = 0; i < FIFO_DEPTH; i++) begin
            send_good(next_byte());
        end
        u_chk.check_flags(1'b1, 1'b0);
        send_frame(build_frame(next_byte(), CORRUPT_NONE)); // the FIFO is full, so this byte is never expected.
        u_chk.check_flags(1'b1, 1'b1);
        u_chk.set_consumer(2, 1'b0);
        wait_idle();
        u_chk.end_test();

        u_chk.report_totals();
        if (u_chk.total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
